//--- sources.f
src/lcd_pkg.sv
src/lcd_timing_gen.sv
src/lcd_pattern_gen.sv
src/lcd_pixel_buffer.sv
src/lcd_out_stage.sv
src/lcd_top.sv
verif/lcd_assertions.sv
verif/tb_lcd_top.sv

//--- src/lcd_out_stage.sv
`default_nettype none

module lcd_out_stage (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          load_i,
    input  wire [lcd_pkg::X_W-1:0]       x_i,
    input  wire [lcd_pkg::Y_W-1:0]       y_i,
    input  wire lcd_pkg::pixel_t         pixel_i,
    input  wire                          nclk_i,
    output logic [lcd_pkg::COLOR_W-1:0]  lcd_r_o,
    output logic [lcd_pkg::COLOR_W-1:0]  lcd_g_o,
    output logic [lcd_pkg::COLOR_W-1:0]  lcd_b_o,
    output logic                         lcd_de_o,
    output logic                         lcd_hsync_o,
    output logic                         lcd_vsync_o,
    output logic                         lcd_nclk_o
);

    lcd_pkg::pixel_t pixel_ff;
    logic            de_ff;
    logic            hsync_ff;
    logic            vsync_ff;
    logic            nclk_ff;
    logic            started_ff;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Panel data, loaded once per slot.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            pixel_ff <= '0;
            de_ff    <= 1'b0;
            hsync_ff <= 1'b0;
            vsync_ff <= 1'b0;
        end else if (load_i) begin
            pixel_ff <= pixel_i;
            de_ff    <= (x_i < lcd_pkg::X_W'(lcd_pkg::H_ACTIVE)) &&
                        (y_i < lcd_pkg::Y_W'(lcd_pkg::V_ACTIVE));
            hsync_ff <= (x_i == lcd_pkg::X_W'(lcd_pkg::H_ACTIVE));
            vsync_ff <= (y_i == lcd_pkg::Y_W'(lcd_pkg::V_ACTIVE));
        end
    end

    // The first slot after reset has no loaded data yet, so the panel
    // clock is held low until the first load has landed.
    always_ff @(posedge clk) begin
        if (rst) begin
            started_ff <= 1'b0;
            nclk_ff    <= 1'b0;
        end else begin
            if (load_i) begin
                started_ff <= 1'b1;
            end
            nclk_ff <= nclk_i && started_ff;
        end
    end

    assign lcd_r_o     = pixel_ff.r;
    assign lcd_g_o     = pixel_ff.g;
    assign lcd_b_o     = pixel_ff.b;
    assign lcd_de_o    = de_ff;
    assign lcd_hsync_o = hsync_ff;
    assign lcd_vsync_o = vsync_ff;
    assign lcd_nclk_o  = nclk_ff;

endmodule

`default_nettype wire

//--- src/lcd_pattern_gen.sv
`default_nettype none

module lcd_pattern_gen (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     enable_i,
    input  wire lcd_pkg::pattern_e  pattern_sel_i,
    input  wire [lcd_pkg::X_W-1:0]  x_i,
    input  wire [lcd_pkg::Y_W-1:0]  y_i,
    input  wire                     pop_i,
    output lcd_pkg::pixel_t         pixel_o,
    output logic                    ack_o
);

    lcd_pkg::pixel_t colour;
    lcd_pkg::pixel_t pixel_ff;
    logic            ack_ff;
    logic [2:0]      bar_idx;
    logic            in_active;
    logic            in_box;

    assign in_active = (x_i < lcd_pkg::X_W'(lcd_pkg::H_ACTIVE)) &&
                       (y_i < lcd_pkg::Y_W'(lcd_pkg::V_ACTIVE));

    assign in_box = (x_i >= lcd_pkg::X_W'(lcd_pkg::BOX_X_LO)) &&
                    (x_i <= lcd_pkg::X_W'(lcd_pkg::BOX_X_HI)) &&
                    (y_i >= lcd_pkg::Y_W'(lcd_pkg::BOX_Y_LO)) &&
                    (y_i <= lcd_pkg::Y_W'(lcd_pkg::BOX_Y_HI));

    // Only meaningful inside the active area, where it stays below 8.
    assign bar_idx = 3'(x_i / lcd_pkg::X_W'(lcd_pkg::BAR_WIDTH));

    always_comb begin
        colour = '0;
        if (in_active) begin
            case (pattern_sel_i)
                lcd_pkg::PAT_BOX: begin
                    if (in_box) begin
                        colour = '1;
                    end
                end
                lcd_pkg::PAT_BARS: begin
                    colour.r = {lcd_pkg::COLOR_W{bar_idx[2]}};
                    colour.g = {lcd_pkg::COLOR_W{bar_idx[1]}};
                    colour.b = {lcd_pkg::COLOR_W{bar_idx[0]}};
                end
                lcd_pkg::PAT_GRADIENT: begin
                    colour.r = x_i[lcd_pkg::COLOR_W-1:0];
                    colour.g = y_i[lcd_pkg::COLOR_W-1:0];
                end
                default: begin
                    colour = '0;
                end
            endcase
        end
    end

    // A disabled generator stays silent, which the buffer sees as a miss.
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_ff <= 1'b0;
        end else begin
            ack_ff <= pop_i && enable_i;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_i && enable_i) begin
            pixel_ff <= colour;
        end
    end

    assign pixel_o = pixel_ff;
    assign ack_o   = ack_ff;

endmodule

`default_nettype wire

//--- src/lcd_pixel_buffer.sv
`default_nettype none

module lcd_pixel_buffer (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   ack_i,
    input  wire lcd_pkg::pixel_t  pixel_i,
    input  wire                   load_i,
    output lcd_pkg::pixel_t       pixel_o,
    output logic                  underrun_o
);

    lcd_pkg::pixel_t pixel_ff;
    logic            fresh_ff;
    logic            underrun_ff;

    // Cleared on reset so a miss straight after reset repeats black.
    always_ff @(posedge clk) begin
        if (rst) begin
            pixel_ff <= '0;
        end else if (ack_i) begin
            pixel_ff <= pixel_i;
        end
    end

    // A load consumes the pending pixel. Finding nothing fresh latches
    // the underrun flag until the next reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            fresh_ff    <= 1'b0;
            underrun_ff <= 1'b0;
        end else begin
            if (load_i) begin
                fresh_ff <= 1'b0;
                if (!fresh_ff) begin
                    underrun_ff <= 1'b1;
                end
            end
            if (ack_i) begin
                fresh_ff <= 1'b1;
            end
        end
    end

    assign pixel_o    = pixel_ff;
    assign underrun_o = underrun_ff;

endmodule

`default_nettype wire

//--- src/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame geometry and coordinate widths.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int H_ACTIVE = 400;
    localparam int H_TOTAL  = 507;
    localparam int V_ACTIVE = 96;
    localparam int V_TOTAL  = 112;

    localparam int X_W = 9;
    localparam int Y_W = 7;

    // Phases within one 16-clock pixel slot.
    localparam int SLOT_CYCLES      = 16;
    localparam int PH_POP           = 0;
    localparam int PH_LOAD          = 14;
    localparam int PH_ADVANCE       = 15;
    localparam int NCLK_HIGH_PHASES = 8;

    localparam int COLOR_W = 6;

    typedef struct packed {
        logic [COLOR_W-1:0] r;
        logic [COLOR_W-1:0] g;
        logic [COLOR_W-1:0] b;
    } pixel_t;

    // Test pattern constants. Box bounds are inclusive.
    localparam int BOX_X_LO  = 21;
    localparam int BOX_X_HI  = 30;
    localparam int BOX_Y_LO  = 11;
    localparam int BOX_Y_HI  = 30;
    localparam int BAR_WIDTH = 50;

    typedef enum logic [1:0] {
        PAT_BOX,
        PAT_BARS,
        PAT_GRADIENT,
        PAT_BLACK
    } pattern_e;

endpackage

`default_nettype wire

//--- src/lcd_timing_gen.sv
`default_nettype none

module lcd_timing_gen (
    input  wire                     clk,
    input  wire                     rst,
    output logic [lcd_pkg::X_W-1:0] scan_x_o,
    output logic [lcd_pkg::Y_W-1:0] scan_y_o,
    output logic                    pop_o,
    output logic                    load_o,
    output logic                    nclk_o
);

    logic [3:0]              phase_ff;
    logic                    pop_ff;
    logic                    load_ff;
    logic                    advance_ff;
    logic                    nclk_ff;
    logic [lcd_pkg::X_W-1:0] x_ff;
    logic [lcd_pkg::Y_W-1:0] y_ff;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Slot phase counter and strobes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            phase_ff <= '0;
        end else if (phase_ff == 4'(lcd_pkg::SLOT_CYCLES - 1)) begin
            phase_ff <= '0;
        end else begin
            phase_ff <= phase_ff + 4'd1;
        end
    end

    // Every strobe lags its phase compare by one clock, so the order
    // within a slot is kept: pop, ack, load, then advance.
    always_ff @(posedge clk) begin
        if (rst) begin
            pop_ff     <= 1'b0;
            load_ff    <= 1'b0;
            advance_ff <= 1'b0;
            nclk_ff    <= 1'b0;
        end else begin
            pop_ff     <= (phase_ff == 4'(lcd_pkg::PH_POP));
            load_ff    <= (phase_ff == 4'(lcd_pkg::PH_LOAD));
            advance_ff <= (phase_ff == 4'(lcd_pkg::PH_ADVANCE));
            nclk_ff    <= (phase_ff < 4'(lcd_pkg::NCLK_HIGH_PHASES));
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Raster position.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // The advance strobe sits in the first clock of a slot, so the new
    // position is settled before that slot's pop and held through its load.
    always_ff @(posedge clk) begin
        if (rst) begin
            x_ff <= '0;
            y_ff <= '0;
        end else if (advance_ff) begin
            if (x_ff == lcd_pkg::X_W'(lcd_pkg::H_TOTAL - 1)) begin
                x_ff <= '0;
                if (y_ff == lcd_pkg::Y_W'(lcd_pkg::V_TOTAL - 1)) begin
                    y_ff <= '0;
                end else begin
                    y_ff <= y_ff + 1'b1;
                end
            end else begin
                x_ff <= x_ff + 1'b1;
            end
        end
    end

    assign scan_x_o = x_ff;
    assign scan_y_o = y_ff;
    assign pop_o    = pop_ff;
    assign load_o   = load_ff;
    assign nclk_o   = nclk_ff;

endmodule

`default_nettype wire

//--- src/lcd_top.sv
`default_nettype none

module lcd_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          enable_i,
    input  wire lcd_pkg::pattern_e       pattern_sel_i,
    output logic [lcd_pkg::COLOR_W-1:0]  lcd_r_o,
    output logic [lcd_pkg::COLOR_W-1:0]  lcd_g_o,
    output logic [lcd_pkg::COLOR_W-1:0]  lcd_b_o,
    output logic                         lcd_de_o,
    output logic                         lcd_hsync_o,
    output logic                         lcd_vsync_o,
    output logic                         lcd_nclk_o,
    output logic                         underrun_o
);

    logic [lcd_pkg::X_W-1:0] scan_x;
    logic [lcd_pkg::Y_W-1:0] scan_y;
    logic                    pop;
    logic                    load;
    logic                    nclk;
    logic                    ack;
    lcd_pkg::pixel_t         gen_pixel;
    lcd_pkg::pixel_t         buf_pixel;

    lcd_timing_gen timing0 (
        .clk      (clk),
        .rst      (rst),
        .scan_x_o (scan_x),
        .scan_y_o (scan_y),
        .pop_o    (pop),
        .load_o   (load),
        .nclk_o   (nclk)
    );

    lcd_pattern_gen pattern0 (
        .clk           (clk),
        .rst           (rst),
        .enable_i      (enable_i),
        .pattern_sel_i (pattern_sel_i),
        .x_i           (scan_x),
        .y_i           (scan_y),
        .pop_i         (pop),
        .pixel_o       (gen_pixel),
        .ack_o         (ack)
    );

    lcd_pixel_buffer buffer0 (
        .clk        (clk),
        .rst        (rst),
        .ack_i      (ack),
        .pixel_i    (gen_pixel),
        .load_i     (load),
        .pixel_o    (buf_pixel),
        .underrun_o (underrun_o)
    );

    lcd_out_stage out0 (
        .clk         (clk),
        .rst         (rst),
        .load_i      (load),
        .x_i         (scan_x),
        .y_i         (scan_y),
        .pixel_i     (buf_pixel),
        .nclk_i      (nclk),
        .lcd_r_o     (lcd_r_o),
        .lcd_g_o     (lcd_g_o),
        .lcd_b_o     (lcd_b_o),
        .lcd_de_o    (lcd_de_o),
        .lcd_hsync_o (lcd_hsync_o),
        .lcd_vsync_o (lcd_vsync_o),
        .lcd_nclk_o  (lcd_nclk_o)
    );

endmodule

`default_nettype wire

//--- verif/lcd_assertions.sv
`default_nettype none

module lcd_assertions (
    input wire                         clk,
    input wire                         rst,
    input wire [lcd_pkg::COLOR_W-1:0]  r_i,
    input wire [lcd_pkg::COLOR_W-1:0]  g_i,
    input wire [lcd_pkg::COLOR_W-1:0]  b_i,
    input wire                         de_i,
    input wire                         hsync_i,
    input wire                         vsync_i,
    input wire                         nclk_i,
    input wire                         underrun_i
);

    int                              fail_count = 0;
    logic [3*lcd_pkg::COLOR_W+2:0]   panel_bus;

    assign panel_bus = {r_i, g_i, b_i, de_i, hsync_i, vsync_i};

    // The panel samples on the rising edge of its clock, so everything it
    // sees must have been settled for the clock before that edge.
    property panel_bus_settled;
        @(posedge clk) disable iff (rst)
            $rose(nclk_i) |-> ($stable(panel_bus) && (panel_bus == $past(panel_bus, 2)));
    endproperty

    property de_outside_syncs;
        @(posedge clk) disable iff (rst)
            !(de_i && (hsync_i || vsync_i));
    endproperty

    property underrun_sticky;
        @(posedge clk) disable iff (rst)
            !$fell(underrun_i);
    endproperty

    settled_a: assert property (panel_bus_settled) else begin
        fail_count++;
        $error("panel data or syncs changed in the clock before a rising panel clock");
    end

    de_a: assert property (de_outside_syncs) else begin
        fail_count++;
        $error("data enable is high together with a sync");
    end

    underrun_a: assert property (underrun_sticky) else begin
        fail_count++;
        $error("underrun flag fell outside reset");
    end

endmodule

bind lcd_top lcd_assertions checks0 (
    .clk        (clk),
    .rst        (rst),
    .r_i        (lcd_r_o),
    .g_i        (lcd_g_o),
    .b_i        (lcd_b_o),
    .de_i       (lcd_de_o),
    .hsync_i    (lcd_hsync_o),
    .vsync_i    (lcd_vsync_o),
    .nclk_i     (lcd_nclk_o),
    .underrun_i (underrun_o)
);

`default_nettype wire

//--- verif/tb_lcd_top.sv
`default_nettype none

module tb_lcd_top;

    logic                        clk;
    logic                        rst;
    logic                        enable;
    lcd_pkg::pattern_e           pattern_sel;
    logic [lcd_pkg::COLOR_W-1:0] lcd_r;
    logic [lcd_pkg::COLOR_W-1:0] lcd_g;
    logic [lcd_pkg::COLOR_W-1:0] lcd_b;
    logic                        lcd_de;
    logic                        lcd_hsync;
    logic                        lcd_vsync;
    logic                        lcd_nclk;
    logic                        underrun;

    // Model state. pos_x and pos_y hold the position of the next sample.
    int                pos_x = 0;
    int                pos_y = 0;
    logic              model_enable;
    lcd_pkg::pattern_e model_pattern;
    logic              model_underrun = 1'b0;
    lcd_pkg::pixel_t   last_ack = '0;
    int                evt_x[$];
    int                evt_y[$];
    logic              evt_en[$];
    lcd_pkg::pattern_e evt_pat[$];
    int                hsync_count = 0;
    int                vsync_count = 0;
    int                samples = 0;
    int                pixel_errors = 0;
    int                sync_errors = 0;
    int                flag_errors = 0;
    longint            cycles = 0;
    longint            cycle_limit;

    lcd_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .enable_i      (enable),
        .pattern_sel_i (pattern_sel),
        .lcd_r_o       (lcd_r),
        .lcd_g_o       (lcd_g),
        .lcd_b_o       (lcd_b),
        .lcd_de_o      (lcd_de),
        .lcd_hsync_o   (lcd_hsync),
        .lcd_vsync_o   (lcd_vsync),
        .lcd_nclk_o    (lcd_nclk),
        .underrun_o    (underrun)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: the tests did not finish within %0d clock cycles", cycle_limit);
            $display("Finished with errors");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic void reference_pixel(input int x, input int y,
                                            input lcd_pkg::pattern_e pat,
                                            output lcd_pkg::pixel_t pix,
                                            output logic de, output logic hs,
                                            output logic vs);
        int bar;
        bar = x / lcd_pkg::BAR_WIDTH;
        de = (x < lcd_pkg::H_ACTIVE) && (y < lcd_pkg::V_ACTIVE);
        hs = (x == lcd_pkg::H_ACTIVE);
        vs = (y == lcd_pkg::V_ACTIVE);
        pix = '0;
        if (de) begin
            case (pat)
                lcd_pkg::PAT_BOX: begin
                    if (x >= lcd_pkg::BOX_X_LO && x <= lcd_pkg::BOX_X_HI &&
                        y >= lcd_pkg::BOX_Y_LO && y <= lcd_pkg::BOX_Y_HI) begin
                        pix = {6'd63, 6'd63, 6'd63};
                    end
                end
                lcd_pkg::PAT_BARS: begin
                    pix.r = bar[2] ? 6'd63 : 6'd0;
                    pix.g = bar[1] ? 6'd63 : 6'd0;
                    pix.b = bar[0] ? 6'd63 : 6'd0;
                end
                lcd_pkg::PAT_GRADIENT: begin
                    pix.r = 6'(x % 64);
                    pix.g = 6'(y % 64);
                end
                default: begin
                    pix = '0;
                end
            endcase
        end
    endfunction

    function automatic int error_total();
        return pixel_errors + sync_errors + flag_errors + dut0.checks0.fail_count;
    endfunction

    function automatic lcd_pkg::pattern_e random_pattern();
        return lcd_pkg::pattern_e'(2'($urandom % 4));
    endfunction

    // One sample per rising panel clock, in raster order from (0,0).
    always @(posedge lcd_nclk) begin : compare
        lcd_pkg::pixel_t exp_pix;
        logic            exp_de;
        logic            exp_hs;
        logic            exp_vs;
        if (evt_x.size() > 0 && evt_x[0] == pos_x && evt_y[0] == pos_y) begin
            model_enable = evt_en.pop_front();
            model_pattern = evt_pat.pop_front();
            void'(evt_x.pop_front());
            void'(evt_y.pop_front());
        end
        reference_pixel(pos_x, pos_y, model_pattern, exp_pix, exp_de, exp_hs, exp_vs);
        if (model_enable) begin
            last_ack = exp_pix;
        end else begin
            exp_pix = last_ack;
            model_underrun = 1'b1;
        end
        samples++;
        if ({lcd_r, lcd_g, lcd_b} !== exp_pix) begin
            $display("mismatch at %0t: pixel at (%0d,%0d) is %h, expected %h",
                     $time, pos_x, pos_y, {lcd_r, lcd_g, lcd_b}, exp_pix);
            pixel_errors++;
        end
        if ({lcd_de, lcd_hsync, lcd_vsync} !== {exp_de, exp_hs, exp_vs}) begin
            $display("mismatch at %0t: de/hsync/vsync at (%0d,%0d) are %b, expected %b",
                     $time, pos_x, pos_y, {lcd_de, lcd_hsync, lcd_vsync},
                     {exp_de, exp_hs, exp_vs});
            sync_errors++;
        end
        if (underrun !== model_underrun) begin
            $display("mismatch at %0t: underrun at (%0d,%0d) is %b, expected %b",
                     $time, pos_x, pos_y, underrun, model_underrun);
            flag_errors++;
        end
        hsync_count += (lcd_hsync === 1'b1) ? 1 : 0;
        vsync_count += (lcd_vsync === 1'b1) ? 1 : 0;
        if (pos_x == lcd_pkg::H_TOTAL - 1) begin
            if (hsync_count != 1) begin
                $display("mismatch at %0t: line %0d had %0d hsync samples, expected 1",
                         $time, pos_y, hsync_count);
                sync_errors++;
            end
            hsync_count = 0;
            if (pos_y == lcd_pkg::V_TOTAL - 1) begin
                if (vsync_count != lcd_pkg::H_TOTAL) begin
                    $display("mismatch at %0t: frame had %0d vsync samples, expected %0d",
                             $time, vsync_count, lcd_pkg::H_TOTAL);
                    sync_errors++;
                end
                vsync_count = 0;
            end
            pos_x = 0;
            pos_y = (pos_y + 1) % lcd_pkg::V_TOTAL;
        end else begin
            pos_x = pos_x + 1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic wait_for_position(input int x, input int y);
        do begin
            @(posedge clk);
        end while (!(pos_x == x && pos_y == y));
    endtask

    // The model reaches the lead position at the sample that coincides with
    // the pop of that position, so new inputs take effect from the one after it.
    task automatic schedule_inputs(input int lead_x, input int lead_y, input logic en,
                                   input lcd_pkg::pattern_e pat);
        wait_for_position(lead_x, lead_y);
        enable <= en;
        pattern_sel <= pat;
        evt_x.push_back((lead_x + 1) % lcd_pkg::H_TOTAL);
        evt_y.push_back(lead_x == lcd_pkg::H_TOTAL - 1 ?
                        (lead_y + 1) % lcd_pkg::V_TOTAL : lead_y);
        evt_en.push_back(en);
        evt_pat.push_back(pat);
    endtask

    task automatic finish_frame(input lcd_pkg::pattern_e next_pat);
        schedule_inputs(lcd_pkg::H_TOTAL - 1, lcd_pkg::V_TOTAL - 1, 1'b1, next_pat);
        wait_for_position(0, 0);
    endtask

    initial begin : stimulus
        int base;
        rst = 1'b1;
        enable = 1'b1;
        pattern_sel = lcd_pkg::PAT_BOX;
        model_enable = 1'b1;
        model_pattern = lcd_pkg::PAT_BOX;
        // Seven test frames, one spare frame and the reset cycles.
        cycle_limit = 8 * lcd_pkg::SLOT_CYCLES * lcd_pkg::H_TOTAL * lcd_pkg::V_TOTAL + 8;
        void'($urandom(41));
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        finish_frame(lcd_pkg::PAT_BARS);
        $display("test 1 box frame: %0d errors", pixel_errors);
        base = pixel_errors;
        finish_frame(lcd_pkg::PAT_GRADIENT);
        finish_frame(random_pattern());
        $display("test 2 bars and gradient frames: %0d errors", pixel_errors - base);
        $display("test 3 blanking and syncs: %0d errors", sync_errors);

        base = error_total();
        finish_frame(random_pattern());
        finish_frame(random_pattern());
        finish_frame(lcd_pkg::PAT_GRADIENT);
        if (underrun !== 1'b0) begin
            $display("underrun flag was raised during the random pattern frames");
            flag_errors++;
        end
        $display("test 4 random pattern switches: %0d errors", error_total() - base);

        // The generator stays silent for ten lines starting mid-line.
        base = error_total();
        schedule_inputs(198, 20, 1'b0, lcd_pkg::PAT_GRADIENT);
        schedule_inputs(198, 30, 1'b1, lcd_pkg::PAT_GRADIENT);
        wait_for_position(0, 0);
        if (underrun !== 1'b1) begin
            $display("underrun flag is not set after the generator was disabled");
            flag_errors++;
        end
        $display("test 5 underrun: %0d errors", error_total() - base);

        $display("summary: %0d samples, %0d pixel, %0d sync, %0d flag, %0d assertion errors",
                 samples, pixel_errors, sync_errors, flag_errors, dut0.checks0.fail_count);
        if (error_total() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
